// File: logic/adc_lane_config.svh
`ifndef ADC_LANE_CONFIG_SVH
`define ADC_LANE_CONFIG_SVH

// bits in one adc sample
`define ADC_SAMPLE_W 10

// bits per lane per lclk_d4 cycle
`define ADC_NIBBLE_W 4

// lclk_d4 cycles in one two-sample frame pair (2 x 10 bits / 4)
`define ADC_SLOTS 5

// fifo entries, keep it a power of two
`define ADC_FIFO_DEPTH 16

`endif

// File: logic/adc_lane_pkg.sv
`include "adc_lane_config.svh"

package adc_lane_pkg;

  // position of the current nibble inside a frame pair, 0 .. ADC_SLOTS-1
  typedef logic [$clog2(`ADC_SLOTS)-1:0] slot_t;

  // both samples of one frame pair on a single lane
  typedef struct packed {
    logic [`ADC_SAMPLE_W-1:0] d0; // first sample, arrives in slots 0..2
    logic [`ADC_SAMPLE_W-1:0] d1; // second sample, slots 2..4
  } lane_words_t;

  // one 16 bit output word of the fifo
  typedef struct packed {
    logic                     tag;    // stream id, 0 = adc0 and 1 = adc1
    logic [14-`ADC_SAMPLE_W:0] pad;   // zero fill up to 16 bits
    logic [`ADC_SAMPLE_W-1:0] sample;
  } fifo_half_t;

  // one stored entry, adc0 sits in the upper half and is read out first
  typedef struct packed {
    fifo_half_t first;  // adc0
    fifo_half_t second; // adc1
  } fifo_entry_t;

endpackage

// File: logic/frame_aligner.sv
`timescale 1ns/1ps
`include "adc_lane_config.svh"

module frame_aligner (
  input  logic                     lclk_d4,
  input  logic                     rst_n,
  input  logic                     sync,
  input  logic [`ADC_NIBBLE_W-1:0] fclk4b,       // deserialized frame clock
  output adc_lane_pkg::slot_t      slot,
  output logic                     word_we,      // one cycle strobe per finished word
  output logic                     word_sel,     // 0 = d0 finished, 1 = d1 finished
  output logic [31:0]              fclk_err_cnt
);
  import adc_lane_pkg::*;

  // legal frame clock sequence, one nibble per cycle
  localparam logic [`ADC_NIBBLE_W-1:0] FCLK_S0 = 4'b1111; // frame start
  localparam logic [`ADC_NIBBLE_W-1:0] FCLK_S1 = 4'b0001;
  localparam logic [`ADC_NIBBLE_W-1:0] FCLK_S2 = 4'b1100;
  localparam logic [`ADC_NIBBLE_W-1:0] FCLK_S3 = 4'b0111;
  localparam logic [`ADC_NIBBLE_W-1:0] FCLK_S4 = 4'b0000; // last nibble of a pair

  localparam slot_t LAST_SLOT = slot_t'(`ADC_SLOTS - 1);
  localparam slot_t D0_SLOT   = slot_t'(2); // d0 bits 9:8 land here

  logic [`ADC_NIBBLE_W-1:0] fclk_q;    // registered nibble
  logic [`ADC_NIBBLE_W-1:0] fclk_prev; // the one before it
  logic [1:0]               fclk_vld;  // [0] fclk_q sampled, [1] fclk_prev sampled
  logic [`ADC_NIBBLE_W-1:0] exp_prev;  // required predecessor of fclk_q
  logic                     legal;
  logic                     fclk_bad;
  logic                     waiting;   // hunting for the end of a frame

  always_ff @(posedge lclk_d4) begin
    fclk_q    <= fclk4b;
    fclk_prev <= fclk_q;
  end

  // predecessor lookup
  always_comb begin
    legal    = 1'b1;
    exp_prev = FCLK_S4;
    case (fclk_q)
      FCLK_S0: exp_prev = FCLK_S4; // wraps from the previous pair
      FCLK_S1: exp_prev = FCLK_S0;
      FCLK_S2: exp_prev = FCLK_S1;
      FCLK_S3: exp_prev = FCLK_S2;
      FCLK_S4: exp_prev = FCLK_S3;
      default: legal = 1'b0; // not part of the pattern at all
    endcase
    // an illegal nibble counts by itself, a legal one only for a bad predecessor
    fclk_bad = fclk_vld[0] & (~legal | (fclk_vld[1] & (fclk_prev != exp_prev)));
  end

  always_ff @(posedge lclk_d4) begin
    if (!rst_n) begin
      fclk_vld     <= 2'b00;
      fclk_err_cnt <= '0;
    end else begin
      fclk_vld <= {fclk_vld[0], 1'b1};
      if (fclk_bad) begin
        fclk_err_cnt <= fclk_err_cnt + 32'd1;
      end
    end
  end

  // slot counter, sync restarts the hunt like reset does
  always_ff @(posedge lclk_d4) begin
    if (!rst_n || sync) begin
      waiting  <= 1'b1;
      slot     <= '0;
      word_we  <= 1'b0;
      word_sel <= 1'b0;
    end else begin
      word_we <= ~waiting & ((slot == D0_SLOT) | (slot == LAST_SLOT));
      if (slot == D0_SLOT) begin
        word_sel <= 1'b0;
      end else if (slot == LAST_SLOT) begin
        word_sel <= 1'b1;
      end
      if (waiting) begin
        // slot stays at 0, so the next nibble lands in slot 0
        if (fclk4b == FCLK_S4) begin
          waiting <= 1'b0;
        end
      end else begin
        slot <= (slot == LAST_SLOT) ? slot_t'(0) : slot_t'(slot + slot_t'(1)); // free running
      end
    end
  end

endmodule

// File: logic/lane_deserializer.sv
`timescale 1ns/1ps
`include "adc_lane_config.svh"

module lane_deserializer (
  input  logic                     lclk_d4,
  input  logic [`ADC_NIBBLE_W-1:0] din4b,  // one lane, lsb first
  input  adc_lane_pkg::slot_t      slot,
  output adc_lane_pkg::lane_words_t words
);

  // two 10 bit words span five 4 bit nibbles
  // slot 2 is shared by the tail of d0 and the head of d1
  //
  //   slot   0       1       2           3       4
  //   bits   d0[3:0] d0[7:4] d0[9:8]     d1[5:2] d1[9:6]
  //                          d1[1:0]

  always_ff @(posedge lclk_d4) begin
    case (slot)
      3'd0: begin
        words.d0[3:0] <= din4b; // start of the pair
      end
      3'd1: begin
        words.d0[7:4] <= din4b;
      end
      3'd2: begin
        words.d0[9:8] <= din4b[1:0]; // d0 complete after this edge
        words.d1[1:0] <= din4b[3:2]; // d1 starts in the same nibble
      end
      3'd3: begin
        words.d1[5:2] <= din4b;
      end
      3'd4: begin
        words.d1[9:6] <= din4b; // d1 complete
      end
      default: begin
        words <= words; // slot never gets here
      end
    endcase
  end

endmodule

// File: logic/sample_fifo.sv
`timescale 1ns/1ps
`include "adc_lane_config.svh"

module sample_fifo (
  input  logic                      lclk_d4,
  input  logic                      rst_n,
  input  adc_lane_pkg::lane_words_t lane0,
  input  adc_lane_pkg::lane_words_t lane1,
  input  logic                      word_we,  // from the aligner
  input  logic                      word_sel, // 0 = d0, 1 = d1
  input  logic                      wr_en,    // external write gate
  input  logic                      rd_en,    // one half per pulse
  output logic [`ADC_SAMPLE_W-1:0]  dout,
  output logic                      sync_out, // tag of the half on dout
  output logic                      empty
);
  import adc_lane_pkg::*;

  localparam int DEPTH = `ADC_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

  fifo_entry_t mem [DEPTH];
  fifo_entry_t wr_entry;
  fifo_entry_t head;      // entry at the read pointer
  fifo_half_t  head_half; // half selected for output
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;   // stored entries
  logic          half_sel; // 0 = first half of head, 1 = second
  logic          full;
  logic          do_wr;
  logic          do_rd;
  logic          pop;

  // pair the matching words of both lanes
  always_comb begin
    wr_entry              = '0; // pad bits stay zero
    wr_entry.first.tag    = 1'b0;
    wr_entry.first.sample = word_sel ? lane0.d1 : lane0.d0;
    wr_entry.second.tag    = 1'b1;
    wr_entry.second.sample = word_sel ? lane1.d1 : lane1.d0;
  end

  assign full  = (count == FULL_CNT);
  assign empty = (count == '0);
  assign do_wr = word_we & wr_en & ~full; // no back pressure, excess is lost
  assign do_rd = rd_en & ~empty;
  assign pop   = do_rd & half_sel;        // second half read frees the entry

  always_ff @(posedge lclk_d4) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge lclk_d4) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      half_sel <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + AW'(1); // wraps at DEPTH
      end
      if (do_rd) begin
        half_sel <= ~half_sel;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      case ({do_wr, pop})
        2'b10:   count <= count + (AW+1)'(1);
        2'b01:   count <= count - (AW+1)'(1);
        default: count <= count; // none, or one in and one out
      endcase
    end
  end

  // first word fall through
  assign head      = mem[rd_ptr];
  assign head_half = half_sel ? head.second : head.first;
  assign dout      = head_half.sample;
  assign sync_out  = head_half.tag;

endmodule

// File: logic/adc_lane_unit.sv
`timescale 1ns/1ps
`include "adc_lane_config.svh"

module adc_lane_unit (
  input  logic                       lclk_d4,
  input  logic                       rst_n,
  input  logic                       sync,         // realign request
  input  logic                       wr_en,
  input  logic                       rd_en,
  input  logic [`ADC_NIBBLE_W-1:0]   fclk4b,       // deserialized frame clock
  input  logic [2*`ADC_NIBBLE_W-1:0] din4b,        // lane1 high, lane0 low
  output logic [31:0]                fclk_err_cnt,
  output logic [`ADC_SAMPLE_W-1:0]   dout,
  output logic                       sync_out,
  output logic                       empty
);
  import adc_lane_pkg::*;

  slot_t       slot;
  logic        word_we;
  logic        word_sel;
  lane_words_t lane0_words;
  lane_words_t lane1_words;

  // frame tracking and word timing
  frame_aligner u_aligner (
    .lclk_d4      (lclk_d4),
    .rst_n        (rst_n),
    .sync         (sync),
    .fclk4b       (fclk4b),
    .slot         (slot),
    .word_we      (word_we),
    .word_sel     (word_sel),
    .fclk_err_cnt (fclk_err_cnt)
  );

  lane_deserializer lane0 (
    .lclk_d4 (lclk_d4),
    .din4b   (din4b[`ADC_NIBBLE_W-1:0]), // adc0 stream
    .slot    (slot),
    .words   (lane0_words)
  );

  lane_deserializer lane1 (
    .lclk_d4 (lclk_d4),
    .din4b   (din4b[2*`ADC_NIBBLE_W-1:`ADC_NIBBLE_W]), // adc1 stream
    .slot    (slot),
    .words   (lane1_words)
  );

  sample_fifo u_fifo (
    .lclk_d4  (lclk_d4),
    .rst_n    (rst_n),
    .lane0    (lane0_words),
    .lane1    (lane1_words),
    .word_we  (word_we),
    .word_sel (word_sel),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .dout     (dout),
    .sync_out (sync_out),
    .empty    (empty)
  );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic lclk_d4,
  output logic rst_n
);

  initial begin
    lclk_d4 = 1'b0;
    forever #10 lclk_d4 = ~lclk_d4; // 20 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(negedge lclk_d4); // two full cycles in reset
    rst_n = 1'b1;
  end

endmodule

// File: bench/adc_lane_checker.sv
`timescale 1ns/1ps
`include "adc_lane_config.svh"

module adc_lane_checker (
  input logic                lclk_d4,
  input logic                rst_n,
  input logic                word_we,
  input logic                empty,
  input logic                fifo_wr,  // entry written on this edge
  input logic                fifo_pop, // entry freed on this edge
  input adc_lane_pkg::slot_t slot
);
  import adc_lane_pkg::*;

  localparam int CW = $clog2(`ADC_FIFO_DEPTH) + 1;

  int          fail_cnt = 0; // failed assertions so far
  logic [CW-1:0] stored;     // entries written and not yet popped

  // own tally of the fifo occupancy
  always_ff @(posedge lclk_d4) begin
    if (!rst_n) begin
      stored <= '0;
    end else if (fifo_wr && !fifo_pop) begin
      stored <= stored + CW'(1);
    end else if (fifo_pop && !fifo_wr) begin
      stored <= stored - CW'(1);
    end
  end

  // d0 and d1 complete two slots apart and never back to back
  word_we_single: assert property (@(posedge lclk_d4) disable iff (!rst_n)
    word_we |=> !word_we)
    else begin
      fail_cnt++;
      $error("word_we high on two cycles in a row");
    end

  empty_flag: assert property (@(posedge lclk_d4) disable iff (!rst_n)
    (stored != '0) |-> !empty)
    else begin
      fail_cnt++;
      $error("empty is high while the fifo holds %0d entries", stored);
    end

  // slot wraps after the last nibble of a pair
  slot_range: assert property (@(posedge lclk_d4) disable iff (!rst_n)
    slot <= slot_t'(`ADC_SLOTS - 1))
    else begin
      fail_cnt++;
      $error("slot counter reached %0d", slot);
    end

endmodule

bind adc_lane_unit adc_lane_checker chk (
  .lclk_d4  (lclk_d4),
  .rst_n    (rst_n),
  .word_we  (word_we),
  .empty    (empty),
  .fifo_wr  (u_fifo.do_wr),
  .fifo_pop (u_fifo.pop),
  .slot     (slot)
);

// File: bench/tb_adc_lane_unit.sv
`timescale 1ns/1ps
`include "adc_lane_config.svh"

module tb_adc_lane_unit;

  localparam int N_FRAMES  = 18;                           // lines in the pattern file
  localparam int STIM_CYC  = (N_FRAMES + 4) * `ADC_SLOTS;  // data plus idle frames
  localparam int DRAIN_CYC = 8 * N_FRAMES;                 // four cycles per read of a record
  localparam int MAX_CYC   = 2 * STIM_CYC + DRAIN_CYC;
  localparam logic [3:0] BAD_NIB = 4'b1010;                // not in the frame pattern
  localparam logic [3:0] FCLK_PAT [5] = '{4'b1111, 4'b0001, 4'b1100, 4'b0111, 4'b0000};

  logic        lclk_d4;
  logic        rst_n;
  logic        sync;
  logic        wr_en;
  logic        rd_en;
  logic [3:0]  fclk4b;
  logic [7:0]  din4b;
  logic [31:0] fclk_err_cnt;
  logic [9:0]  dout;
  logic        sync_out;
  logic        empty;

  // {ctrl[7:0], flags a, adc0 a, adc1 a, flags b, adc0 b, adc1 b}
  logic [63:0] pat [N_FRAMES];
  logic [10:0] exp_q [$];   // {tag, sample} in read order
  logic [3:0]  prev_fclk;   // last frame nibble driven
  logic        pend_wr;     // wr_en for the d1 write that lands in the next frame
  int          mismatches;
  int          failures;
  int          exp_breaks;
  int          stall;
  int          cycles = 0;

  tb_clock_gen clk_gen (.lclk_d4(lclk_d4), .rst_n(rst_n));

  adc_lane_unit dut (
    .lclk_d4(lclk_d4), .rst_n(rst_n), .sync(sync), .wr_en(wr_en), .rd_en(rd_en),
    .fclk4b(fclk4b), .din4b(din4b), .fclk_err_cnt(fclk_err_cnt), .dout(dout),
    .sync_out(sync_out), .empty(empty)
  );

  // a nibble breaks the frame when it is illegal or follows the wrong one
  function automatic logic frame_break(input logic [3:0] prev, input logic [3:0] cur);
    for (int k = 0; k < 5; k++) begin
      if (cur == FCLK_PAT[k]) begin
        return prev != FCLK_PAT[(k + 4) % 5];
      end
    end
    return 1'b1;
  endfunction

  task automatic expect_entry(input logic [9:0] s0, input logic [9:0] s1);
    if (exp_q.size() < 2 * `ADC_FIFO_DEPTH) begin // full fifo loses the pair
      exp_q.push_back({1'b0, s0});
      exp_q.push_back({1'b1, s1});
    end
  endtask

  // one lclk_d4 cycle with inputs changing on the falling edge
  task automatic step(input logic [3:0] fclk, input logic [7:0] din, input logic wr,
                      input logic sy, input logic rd_ok);
    logic [10:0] exp_half;
    @(negedge lclk_d4);
    rd_en = 1'b0;
    if (rd_ok && !empty) begin
      assert (exp_q.size() != 0) else begin
        failures++;
        $display("%0t: fifo returned sample %h that was never written", $time, dout);
      end
      if (exp_q.size() != 0) begin
        exp_half = exp_q.pop_front();
        assert (dout == exp_half[9:0]) else begin
          mismatches++;
          $display("mismatch at %0t: dout expected %h got %h", $time, exp_half[9:0], dout);
        end
        assert (sync_out == exp_half[10]) else begin
          mismatches++;
          $display("mismatch at %0t: sync_out expected %b got %b", $time, exp_half[10],
                   sync_out);
        end
      end
      rd_en = 1'b1;
      stall = 0;
    end else if (rd_ok && exp_q.size() != 0) begin
      stall++; // the last write may still be on its way
      assert (stall <= 2 * `ADC_SLOTS) else begin
        failures++;
        $display("%0t: fifo stays empty while %0d samples are expected", $time, exp_q.size());
        exp_q.delete();
      end
    end
    if (frame_break(prev_fclk, fclk)) begin
      exp_breaks++;
    end
    prev_fclk = fclk;
    fclk4b    = fclk;
    din4b     = din;
    wr_en     = wr;
    sync      = sy;
  endtask

  task automatic run_idle(input int frames, input logic rd_ok);
    for (int f = 0; f < frames; f++) begin
      for (int i = 0; i < 5; i++) begin
        step(FCLK_PAT[i], 8'h00, (i == 0) ? pend_wr : 1'b0, 1'b0, rd_ok);
        pend_wr = 1'b0;
      end
    end
  endtask

  // serialize one frame pair of two records lsb first on each lane
  task automatic send_frame(input logic [63:0] rec);
    logic [19:0] lane0_bits;
    logic [19:0] lane1_bits;
    logic [3:0]  fclk;
    logic        wr;
    lane0_bits = {rec[21:12], rec[49:40]}; // adc0 stream with the second sample on top
    lane1_bits = {rec[9:0], rec[37:28]};   // adc1 stream
    for (int i = 0; i < 5; i++) begin
      fclk = FCLK_PAT[i];
      if ((i == 1 && rec[53]) || (i == 3 && rec[25])) begin
        fclk = BAD_NIB;
      end
      wr = (i == 0) ? pend_wr : ((i <= 3) ? rec[52] : rec[24]); // d0 write in slot 3 cycle
      step(fclk, {lane1_bits[4*i +: 4], lane0_bits[4*i +: 4]}, wr, rec[56] && (i == 1), 1'b0);
    end
    pend_wr = rec[24] && !rec[56];
    if (!rec[56]) begin // a pair cut by sync is lost
      if (rec[52]) expect_entry(rec[49:40], rec[37:28]);
      if (rec[24]) expect_entry(rec[21:12], rec[9:0]);
    end
  endtask

  task automatic drain_fifo();
    stall = 0;
    run_idle(1, 1'b1);
    while (exp_q.size() != 0 || !empty) begin
      run_idle(1, 1'b1);
    end
  endtask

  initial begin
    sync       = 1'b0;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    fclk4b     = 4'b0000;
    din4b      = 8'h00;
    prev_fclk  = 4'b0000;
    pend_wr    = 1'b0;
    mismatches = 0;
    failures   = 0;
    exp_breaks = 0;
    stall      = 0;
    $readmemh("bench/adc_lane_patterns.hex", pat);
    run_idle(3, 1'b0); // reset and then the aligner locks on a frame end
    for (int n = 0; n < N_FRAMES; n++) begin
      send_frame(pat[n]);
      if (pat[n][57]) begin
        drain_fifo();
      end
    end
    run_idle(1, 1'b0);
    assert (fclk_err_cnt == exp_breaks) else begin
      mismatches++;
      $display("mismatch at %0t: fclk_err_cnt expected %0d got %0d", $time, exp_breaks,
               fclk_err_cnt);
    end
    failures += dut.chk.fail_cnt;
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  always @(posedge lclk_d4) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYC) begin
      $display("timeout after %0d cycles and the run did not finish", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+logic
logic/adc_lane_pkg.sv
logic/frame_aligner.sv
logic/lane_deserializer.sv
logic/sample_fifo.sv
logic/adc_lane_unit.sv
bench/tb_clock_gen.sv
bench/adc_lane_checker.sv
bench/tb_adc_lane_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the adc lane unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_adc_lane_unit -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/tb_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: bench/adc_lane_patterns.hex
// one frame pair per line: ctrl(1 sync, 2 drain after) | flags a | adc0 a | adc1 a
// | flags b | adc0 b | adc1 b ; flags are 1 wr_en, 2 corrupt frame nibble
0011552AA13FF001
0011230CC03E71B5
0212000F010A535A
0031112221333044
0212D212D30FF300
0010AB1CD12EF301
01115515512AA2AA
02101E3C3124639B
0010103EF10213DE
0010323CD10433BC
0010543AB106539A
0010763891087378
00109836710A9356
0010BA34510CB334
0010DC32310ED312
0010FE301110F2F0
0211A125E11B224D
0212C313C13D402B
